// ==== cache_controller/cache_controller.sv ====
module cache_controller #(
  parameter int INDEX_W = 6
) (
  input  logic               clk,
  input  logic               i_rst,
  input  mem_pkg::word_t     i_i_addr,
  input  mem_pkg::word_t     i_d_addr,
  input  logic               i_re,
  input  logic               i_we,
  input  mem_pkg::word_t     i_wrt_data,
  input  mem_pkg::cache_rd_t i_i_rd,
  input  mem_pkg::cache_rd_t i_d_rd,
  output mem_pkg::cache_wr_t o_i_wr,
  output mem_pkg::cache_wr_t o_d_wr,
  output mem_pkg::mem_req_t  o_mreq,
  input  mem_pkg::block_t    i_m_rd_data,
  input  logic               i_m_done,
  output logic               o_i_rdy,
  output logic               o_d_rdy,
  output logic               o_allow_hlt
);

  import mem_pkg::*;

  localparam int TAG_W = BLK_ADDR_W - INDEX_W;

  ctrl_state_e state_q;

  logic      d_req;        // data access requested
  logic      d_miss;       // data access pending, no hit
  logic      i_miss;       // fetch always requests
  logic      serve_ok;     // lookup result may be used
  logic      fill_done;    // fill block arriving this cycle
  word_sel_t d_sel;
  blk_addr_t d_blk;
  blk_addr_t i_blk;
  blk_addr_t victim_blk;   // dirty line's own address
  block_t    merged;       // data line with the write word in place

  logic      fill_d_q;     // fill target, 1 = dcache
  logic      mem_re_q;
  logic      mem_we_q;
  blk_addr_t mem_addr_q;
  block_t    mem_wdata_q;

  assign d_req      = i_re | i_we;
  assign d_miss     = d_req & ~i_d_rd.hit;
  assign i_miss     = ~i_i_rd.hit;
  assign d_sel      = i_d_addr[1:0];
  assign d_blk      = i_d_addr[15:2];
  assign i_blk      = i_i_addr[15:2];
  assign victim_blk = {i_d_rd.tag[TAG_W-1:0], d_blk[INDEX_W-1:0]};  // stored tag + index
  assign serve_ok   = (state_q == IDLE) | (state_q == DONE);
  assign fill_done  = (state_q == FILL_WAIT) & i_m_done;

  // word merge for writes
  always_comb begin
    merged = i_d_rd.data;
    merged[{d_sel, 4'h0} +: 16] = i_wrt_data;
  end

  // miss FSM, data miss wins over fetch miss
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q  <= IDLE;
      mem_re_q <= 1'b0;
      mem_we_q <= 1'b0;
      fill_d_q <= 1'b0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (d_miss) begin
            fill_d_q <= 1'b1;
            if (i_d_rd.dirty) begin
              mem_we_q <= 1'b1;  // old line goes out first
              state_q  <= WB;
            end else begin
              mem_re_q <= 1'b1;
              state_q  <= FILL_RD;
            end
          end else if (i_miss) begin
            fill_d_q <= 1'b0;
            mem_re_q <= 1'b1;
            state_q  <= FILL_RD;
          end
        end
        WB:      state_q <= WB_WAIT;  // first write cycle
        WB_WAIT: begin
          if (i_m_done) begin
            mem_we_q <= 1'b0;
            mem_re_q <= 1'b1;  // fill presented the cycle after done
            state_q  <= FILL_RD;
          end
        end
        FILL_RD: state_q <= FILL_WAIT;  // first read cycle
        FILL_WAIT: begin
          if (i_m_done) begin
            mem_re_q <= 1'b0;
            state_q  <= DONE;  // line written at this edge
          end
        end
        DONE:    state_q <= IDLE;  // lookup now hits
        default: state_q <= IDLE;
      endcase
    end
  end

  // request payload, loaded only when a transfer starts
  always_ff @(posedge clk) begin
    if (state_q == IDLE && d_miss) begin
      mem_addr_q  <= i_d_rd.dirty ? victim_blk : d_blk;
      mem_wdata_q <= i_d_rd.data;
    end else if (state_q == IDLE && i_miss) begin
      mem_addr_q <= i_blk;
    end else if (state_q == WB_WAIT && i_m_done) begin
      mem_addr_q <= d_blk;  // fill of the missing line
    end
  end

  assign o_mreq = '{addr: mem_addr_q, re: mem_re_q, we: mem_we_q, wdata: mem_wdata_q};

  // icache only ever takes clean fills
  assign o_i_wr = '{we: fill_done & ~fill_d_q, dirty: 1'b0, data: i_m_rd_data};

  always_comb begin
    o_d_wr = '{we: 1'b0, dirty: 1'b0, data: merged};
    if (fill_done && fill_d_q) begin
      o_d_wr = '{we: 1'b1, dirty: 1'b0, data: i_m_rd_data};  // clean fill
    end else if (serve_ok && i_we && i_d_rd.hit) begin
      o_d_wr = '{we: 1'b1, dirty: 1'b1, data: merged};       // write hit or post-fill write
    end
  end

  assign o_i_rdy     = serve_ok & i_i_rd.hit;
  assign o_d_rdy     = serve_ok & d_req & i_d_rd.hit;
  assign o_allow_hlt = (state_q == IDLE) & ~d_miss & ~i_miss;  // nothing in flight

endmodule

// ==== common/mem_pkg.sv ====
package mem_pkg;

  localparam int WORD_W     = 16;         // processor word
  localparam int WORDS_PER  = 4;          // words per block
  localparam int BLOCK_W    = WORD_W * WORDS_PER;
  localparam int BLK_ADDR_W = 14;         // word address minus the two low bits
  localparam int TAG_MAX_W  = BLK_ADDR_W; // widest tag, index of zero bits

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [BLOCK_W-1:0]    block_t;
  typedef logic [BLK_ADDR_W-1:0] blk_addr_t;
  typedef logic [1:0]            word_sel_t;  // word inside a block
  typedef logic [TAG_MAX_W-1:0]  tag_t;       // upper bits zero when tag is narrower

  // request to main memory, held steady until done
  typedef struct packed {
    blk_addr_t addr;   // block address
    logic      re;     // block read
    logic      we;     // block write
    block_t    wdata;  // write-back block
  } mem_req_t;

  // controller to cache line write
  typedef struct packed {
    logic   we;        // store line, set valid
    logic   dirty;     // dirty bit to store
    block_t data;      // line contents
  } cache_wr_t;

  // cache lookup result, combinational from the address
  typedef struct packed {
    block_t data;      // stored line at the index
    tag_t   tag;       // stored tag, zero extended
    logic   hit;       // valid and tag match
    logic   dirty;     // valid and dirty
  } cache_rd_t;

  typedef enum logic [2:0] {
    IDLE, WB, WB_WAIT, FILL_RD, FILL_WAIT, DONE
  } ctrl_state_e;

endpackage

// ==== dv/mem_hierarchy_sva.sv ====
module mem_hierarchy_sva (
  input logic              clk,
  input logic              i_rst,
  input mem_pkg::mem_req_t i_mreq,
  input logic              i_m_done,
  input logic              i_allow_hlt
);

  timeunit 1ns;
  timeprecision 1ps;

  logic mem_en;  // any transfer presented

  assign mem_en = i_mreq.re | i_mreq.we;

  // one direction per transfer
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (i_rst)
    !(i_mreq.re && i_mreq.we))
    else $error("memory read and write enables high together");

  // memory samples the request only at the end of its latency
  a_req_stable: assert property (@(posedge clk) disable iff (i_rst)
    mem_en && !i_m_done |=> $stable(i_mreq))
    else $error("memory request changed before done");

  a_no_hlt: assert property (@(posedge clk) disable iff (i_rst)
    mem_en |-> !i_allow_hlt)
    else $error("halt allowed while a memory transfer is in flight");

endmodule

// ==== dv/mem_hierarchy_tb.sv ====
module mem_hierarchy_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;

  localparam int MEM_LAT  = 4;                       // DUT default
  localparam int RAND_OPS = 300;
  localparam int OP_COST  = 2 * (MEM_LAT + 2) + 4;   // write-back + fill + handshake
  localparam int TIMEOUT  = (RAND_OPS + 20) * OP_COST + 200;

  logic  clk, rst;
  word_t i_i_addr, i_d_addr, i_wrt_data;
  logic  i_re, i_we;
  word_t o_instr, o_rd_data;
  logic  o_i_rdy, o_d_rdy, o_allow_hlt;

  word_t       wr_mem [word_t];  // words written so far
  logic        check_hlt;        // expect halt allowed this cycle
  logic [31:0] seed;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  tb_clock u_clk (.o_clk(clk), .o_rst(rst));

  mem_hierarchy DUT (
    .clk(clk), .i_rst(rst),
    .i_i_addr(i_i_addr), .i_d_addr(i_d_addr),
    .i_re(i_re), .i_we(i_we), .i_wrt_data(i_wrt_data),
    .o_instr(o_instr), .o_i_rdy(o_i_rdy),
    .o_rd_data(o_rd_data), .o_d_rdy(o_d_rdy), .o_allow_hlt(o_allow_hlt)
  );

  bind cache_controller mem_hierarchy_sva u_sva (
    .clk(clk), .i_rst(i_rst), .i_mreq(o_mreq), .i_m_done(i_m_done),
    .i_allow_hlt(o_allow_hlt)
  );

  // memory starts with every word equal to its own address
  function automatic word_t expect_word(input word_t a);
    if (wr_mem.exists(a)) return wr_mem[a];
    return a;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // wait for the ready flag, then step to the next drive point
  task automatic wait_ready(input logic is_fetch);
    do begin
      @(negedge clk);
    end while (is_fetch ? !o_i_rdy : !o_d_rdy);
    @(posedge clk);
    #1;
  endtask

  task automatic fetch(input word_t a);
    i_i_addr = a;
    wait_ready(1'b1);
  endtask

  task automatic data_op(input logic we, input word_t a, input word_t d);
    i_d_addr   = a;
    i_re       = ~we;
    i_we       = we;
    i_wrt_data = d;
    wait_ready(1'b0);
    i_re = 1'b0;  // request dropped after acceptance
    i_we = 1'b0;
  endtask

  // compare at the negedge, inputs and outputs settled
  always @(negedge clk) begin
    if (!rst) begin
      if (o_i_rdy) begin
        checks++;
        assert (o_instr == expect_word(i_i_addr)) else begin
          errors++;
          $display("[ERROR] o_instr at %h: got %h, expected %h",
                   i_i_addr, o_instr, expect_word(i_i_addr));
        end
      end
      if (o_d_rdy && i_re) begin
        checks++;
        assert (o_rd_data == expect_word(i_d_addr)) else begin
          errors++;
          $display("[ERROR] o_rd_data at %h: got %h, expected %h",
                   i_d_addr, o_rd_data, expect_word(i_d_addr));
        end
      end
      if (o_d_rdy && i_we) wr_mem[i_d_addr] = i_wrt_data;  // write commits this edge
      if (!o_i_rdy || ((i_re || i_we) && !o_d_rdy)) begin
        checks++;
        assert (!o_allow_hlt) else begin
          errors++;
          $display("[ERROR] o_allow_hlt: got %h, expected 0 while a request waits",
                   o_allow_hlt);
        end
      end
      if (check_hlt) begin
        checks++;
        assert (o_allow_hlt) else begin
          errors++;
          $display("[ERROR] o_allow_hlt: got %h, expected 1 when idle", o_allow_hlt);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: no ready flag within %0d cycles", TIMEOUT);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    word_t      a;
    logic [1:0] op;
    i_i_addr   = 16'h8000;  // first fetch, presented out of reset
    i_d_addr   = '0;
    i_re       = 1'b0;
    i_we       = 1'b0;
    i_wrt_data = '0;
    check_hlt  = 1'b0;
    seed       = 32'he5ec;
    @(posedge clk);
    while (rst) @(posedge clk);
    #1;
    wait_ready(1'b1);  // cold fetch
    check_hlt = 1'b1;  // idle, fetch hits, no data access
    @(posedge clk);
    #1;
    check_hlt = 1'b0;
    fetch(16'h8003);  // every word of the block
    fetch(16'h8001);
    fetch(16'h8002);
    fetch(16'h8000);
    data_op(1'b1, 16'h4024, 16'hbeef);
    for (int w = 0; w < 4; w++) data_op(1'b0, 16'h4024 + word_t'(w), '0);
    data_op(1'b1, 16'h4110, 16'h1234);  // index 4
    data_op(1'b1, 16'h4210, 16'h5678);  // same index, dirty victim
    data_op(1'b0, 16'h4110, '0);        // back from main memory
    data_op(1'b0, 16'h4210, '0);
    for (int n = 0; n < RAND_OPS; n++) begin
      seed = lcg_next(seed);
      op   = seed[31:30];
      a    = {2'b01, 4'h0, seed[17:16], 4'h0, seed[13:12], seed[9:8]};  // 4 tags x 4 lines
      case (op)
        2'd0:    fetch(a ^ 16'hc000);  // code window, never written
        2'd1:    data_op(1'b0, a, '0);
        default: data_op(1'b1, a, seed[27:12]);
      endcase
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
  output logic o_clk,
  output logic o_rst
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_NS    = 2;   // 4 ns period
  localparam int RST_CYCLES = 10;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_rst = 1'b0;  // released off the edge, like the stimulus
  end

endmodule

// ==== hdl/cache.sv ====
module cache #(
  parameter int INDEX_W = 6
) (
  input  logic                clk,
  input  logic                i_rst,
  input  mem_pkg::blk_addr_t  i_addr,
  input  mem_pkg::cache_wr_t  i_wr,
  output mem_pkg::cache_rd_t  o_rd
);

  import mem_pkg::*;

  localparam int TAG_W = BLK_ADDR_W - INDEX_W;  // high address bits
  localparam int DEPTH = 1 << INDEX_W;          // lines

  block_t             data_mem [DEPTH];  // line store
  logic [TAG_W-1:0]   tag_mem  [DEPTH];  // tag store
  logic [DEPTH-1:0]   valid_q;           // per-line valid
  logic [DEPTH-1:0]   dirty_q;           // per-line dirty

  logic [INDEX_W-1:0] idx;
  logic [TAG_W-1:0]   addr_tag;
  logic               line_valid;
  logic               tag_match;

  assign idx      = i_addr[INDEX_W-1:0];           // low block address bits
  assign addr_tag = i_addr[BLK_ADDR_W-1:INDEX_W];  // remaining high bits

  // line and tag store, written on fill or write merge
  always_ff @(posedge clk) begin
    if (i_wr.we) begin
      data_mem[idx] <= i_wr.data;
      tag_mem[idx]  <= addr_tag;
    end
  end

  // status bits cleared by reset
  always_ff @(posedge clk) begin
    if (i_rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (i_wr.we) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= i_wr.dirty;
    end
  end

  assign line_valid = valid_q[idx];
  assign tag_match  = (tag_mem[idx] == addr_tag);

  // lookup, purely combinational from the current address
  always_comb begin
    o_rd.data  = data_mem[idx];
    o_rd.tag   = tag_t'(tag_mem[idx]);     // zero extend to full width
    o_rd.hit   = line_valid & tag_match;
    o_rd.dirty = line_valid & dirty_q[idx];  // victim needs write-back
  end

endmodule

// ==== hdl/mem_hierarchy.sv ====
module mem_hierarchy #(
  parameter int INDEX_W = 6,
  parameter int MEM_LAT = 4
) (
  input  logic           clk,
  input  logic           i_rst,
  input  mem_pkg::word_t i_i_addr,
  input  mem_pkg::word_t i_d_addr,
  input  logic           i_re,
  input  logic           i_we,
  input  mem_pkg::word_t i_wrt_data,
  output mem_pkg::word_t o_instr,
  output logic           o_i_rdy,
  output mem_pkg::word_t o_rd_data,
  output logic           o_d_rdy,
  output logic           o_allow_hlt
);

  import mem_pkg::*;

  cache_rd_t icache_rd, dcache_rd;
  cache_wr_t icache_wr, dcache_wr;
  mem_req_t  mreq;
  block_t    m_rd_data;
  logic      m_done;
  word_sel_t i_sel, d_sel;

  cache #(.INDEX_W(INDEX_W)) icache (
    .clk(clk), .i_rst(i_rst), .i_addr(i_i_addr[15:2]), .i_wr(icache_wr), .o_rd(icache_rd)
  );

  cache #(.INDEX_W(INDEX_W)) dcache (
    .clk(clk), .i_rst(i_rst), .i_addr(i_d_addr[15:2]), .i_wr(dcache_wr), .o_rd(dcache_rd)
  );

  cache_controller #(.INDEX_W(INDEX_W)) u_ctrl (
    .clk(clk), .i_rst(i_rst),
    .i_i_addr(i_i_addr), .i_d_addr(i_d_addr),
    .i_re(i_re), .i_we(i_we), .i_wrt_data(i_wrt_data),
    .i_i_rd(icache_rd), .i_d_rd(dcache_rd),
    .o_i_wr(icache_wr), .o_d_wr(dcache_wr),
    .o_mreq(mreq), .i_m_rd_data(m_rd_data), .i_m_done(m_done),
    .o_i_rdy(o_i_rdy), .o_d_rdy(o_d_rdy), .o_allow_hlt(o_allow_hlt)
  );

  unified_mem #(.MEM_LAT(MEM_LAT)) u_mem (
    .clk(clk), .i_rst(i_rst), .i_req(mreq), .o_rd_data(m_rd_data), .o_done(m_done)
  );

  assign i_sel = i_i_addr[1:0];  // word within block
  assign d_sel = i_d_addr[1:0];

  // word select, combinational so a hit returns in the same cycle
  always_comb begin
    o_instr   = icache_rd.data[{i_sel, 4'h0} +: 16];
    o_rd_data = dcache_rd.data[{d_sel, 4'h0} +: 16];
  end

endmodule

// ==== hdl/unified_mem.sv ====
module unified_mem #(
  parameter int MEM_LAT = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  input  mem_pkg::mem_req_t i_req,
  output mem_pkg::block_t   o_rd_data,
  output logic              o_done
);

  import mem_pkg::*;

  localparam int DEPTH = 1 << BLK_ADDR_W;     // 16K blocks
  localparam int CNT_W = $clog2(MEM_LAT + 1);

  block_t           mem [DEPTH];
  logic [CNT_W-1:0] cnt_q;   // cycles the request has been presented
  logic             busy;    // request seen, not the done cycle
  logic             access;  // last latency cycle

  // each word holds its own word address
  initial begin
    for (int b = 0; b < DEPTH; b++) begin
      for (int w = 0; w < WORDS_PER; w++) begin
        mem[b][w*WORD_W +: WORD_W] = WORD_W'(b * WORDS_PER + w);
      end
    end
  end

  assign busy   = (i_req.re | i_req.we) & ~o_done;  // ignore held request during done
  assign access = busy & (cnt_q == CNT_W'(MEM_LAT - 1));

  always_ff @(posedge clk) begin
    if (i_rst) begin
      cnt_q  <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= access;  // one-cycle pulse
      if (access) begin
        cnt_q <= '0;
      end else if (busy) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // block transfer at the end of the latency
  always_ff @(posedge clk) begin
    if (access) begin
      if (i_req.we) begin
        mem[i_req.addr] <= i_req.wdata;
      end
      if (i_req.re) begin
        o_rd_data <= mem[i_req.addr];
      end
    end
  end

endmodule

// ==== mem_hierarchy.f ====
common/mem_pkg.sv
hdl/cache.sv
cache_controller/cache_controller.sv
hdl/unified_mem.sv
hdl/mem_hierarchy.sv
dv/tb_clock.sv
dv/mem_hierarchy_sva.sv
dv/mem_hierarchy_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f mem_hierarchy.f \
  --top-module mem_hierarchy_tb --Mdir obj_dir -o mem_hierarchy_sim || exit 1
out=$(./obj_dir/mem_hierarchy_sim)
echo "$out"
echo "$out" | grep -q "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
